// File: verilog/npc_pkg.sv
// Core widths, reset PC and decode enums shared across the npc core
`default_nettype none

package npc_pkg;

  localparam int XLEN = 64;
  localparam int ILEN = 32;
  localparam logic [XLEN-1:0] PC_RESET = '0;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY_B
  } alu_op_e;

  // Unsigned compares share BLT/BGE, the ALU op tells them apart
  typedef enum logic [2:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_BEQ  = 3'b100,
    BR_BNE  = 3'b101,
    BR_BLT  = 3'b110,
    BR_BGE  = 3'b111
  } branch_e;

  typedef enum logic [2:0] {
    MEM_B = 3'b000, MEM_H = 3'b001, MEM_W = 3'b010, MEM_D = 3'b011,
    MEM_BU = 3'b100, MEM_HU = 3'b101, MEM_WU = 3'b110
  } mem_op_e;

  typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} alu_src_b_e;

endpackage

`default_nettype wire

// File: verilog/npc_ctrl_if.sv
// Decoded control and operand bundle with per-block modports
`default_nettype none

interface npc_ctrl_if;
  import npc_pkg::*;

  logic [XLEN-1:0] imm;
  logic [4:0]      ra, rb, rd;
  logic            reg_wr;
  logic            alu_a_src;   // 0 rs1, 1 pc
  alu_src_b_e      alu_b_src;
  alu_op_e         alu_ctr;
  branch_e         branch;
  logic            mem_to_reg;
  logic            mem_wr;
  mem_op_e         mem_op;

  modport idu_mp (output imm, ra, rb, rd, reg_wr, alu_a_src, alu_b_src, alu_ctr,
                  branch, mem_to_reg, mem_wr, mem_op);
  modport exu_mp (input alu_a_src, alu_b_src, alu_ctr, imm);
  modport bru_mp (input branch, imm);
  modport lsu_mp (input mem_wr, mem_op);

endinterface

`default_nettype wire

// File: verilog/npc_ifu.sv
// Instruction memory with load port and combinational fetch
`default_nettype none

module npc_ifu #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic                          i_clk,
  input  logic                          i_imem_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
  input  logic [npc_pkg::ILEN-1:0]      i_imem_data,
  input  logic [npc_pkg::XLEN-1:0]      i_pc,
  output logic [npc_pkg::ILEN-1:0]      o_inst
);
  import npc_pkg::*;

  localparam int AW = $clog2(IMEM_DEPTH);

  logic [ILEN-1:0] imem [IMEM_DEPTH];

  always_ff @(posedge i_clk) begin
    if (i_imem_we) imem[i_imem_addr] <= i_imem_data;
  end

  assign o_inst = imem[i_pc[AW+1:2]];   // Word index, wraps at depth

endmodule

`default_nettype wire

// File: verilog/npc_bru.sv
// Branch decision, next-PC adder and program counter register
`default_nettype none

module npc_bru (
  input  logic                     i_clk,
  input  logic                     i_reset,
  npc_ctrl_if.bru_mp               ctrl,
  input  logic [npc_pkg::XLEN-1:0] i_rs1,
  input  logic                     i_less,
  input  logic                     i_zero,
  output logic [npc_pkg::XLEN-1:0] o_pc
);
  import npc_pkg::*;

  logic            take;      // Offset is imm rather than 4
  logic            base_rs1;  // Adder base is rs1 rather than pc
  logic [XLEN-1:0] sum;

  always_comb begin
    take     = 1'b0;
    base_rs1 = 1'b0;
    case (ctrl.branch)
      BR_JAL:  take = 1'b1;
      BR_JALR: begin
        take     = 1'b1;
        base_rs1 = 1'b1;
      end
      BR_BEQ:  take = i_zero;
      BR_BNE:  take = ~i_zero;
      BR_BLT:  take = i_less;
      BR_BGE:  take = ~i_less;
      default: take = 1'b0;
    endcase
  end

  assign sum = (base_rs1 ? i_rs1 : o_pc) + (take ? ctrl.imm : XLEN'(4));

  always_ff @(posedge i_clk) begin
    if (i_reset) o_pc <= PC_RESET;
    else         o_pc <= {sum[XLEN-1:1], sum[0] & ~base_rs1};  // JALR drops bit 0
  end

endmodule

`default_nettype wire

// File: verilog/npc_idu.sv
// Instruction decoder and immediate generator
`default_nettype none

module npc_idu (
  input  logic [npc_pkg::ILEN-1:0] i_inst,
  npc_ctrl_if.idu_mp               ctrl
);
  import npc_pkg::*;

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic            reg_wr;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  // Bit 30 picks SUB only for register ops, SRA for both
  function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt,
                                             input logic is_reg);
    case (f3)
      3'b000:  return (is_reg && alt) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];

  // ##########################################################################
  // Immediates
  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  // ##########################################################################
  // Control decode
  always_comb begin
    ctrl.ra         = i_inst[19:15];
    ctrl.rb         = i_inst[24:20];
    ctrl.rd         = i_inst[11:7];
    ctrl.imm        = '0;
    reg_wr          = 1'b0;
    ctrl.alu_a_src  = 1'b0;
    ctrl.alu_b_src  = SRC_B_RS2;
    ctrl.alu_ctr    = ALU_ADD;
    ctrl.branch     = BR_NONE;
    ctrl.mem_to_reg = 1'b0;
    ctrl.mem_wr     = 1'b0;
    ctrl.mem_op     = MEM_B;
    case (opcode)
      OPC_LUI: begin
        reg_wr = 1'b1;  ctrl.imm = imm_u;
        ctrl.alu_b_src = SRC_B_IMM;  ctrl.alu_ctr = ALU_COPY_B;
      end
      OPC_AUIPC: begin
        reg_wr = 1'b1;  ctrl.imm = imm_u;
        ctrl.alu_a_src = 1'b1;  ctrl.alu_b_src = SRC_B_IMM;
      end
      OPC_JAL, OPC_JALR: begin  // Link is pc + 4 through the ALU
        reg_wr = 1'b1;
        ctrl.alu_a_src = 1'b1;  ctrl.alu_b_src = SRC_B_FOUR;
        ctrl.imm    = (opcode == OPC_JAL) ? imm_j : imm_i;
        ctrl.branch = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
      end
      OPC_BRANCH: begin
        ctrl.imm = imm_b;
        case (funct3)
          3'b000:  begin ctrl.branch = BR_BEQ;  ctrl.alu_ctr = ALU_SUB;  end
          3'b001:  begin ctrl.branch = BR_BNE;  ctrl.alu_ctr = ALU_SUB;  end
          3'b100:  begin ctrl.branch = BR_BLT;  ctrl.alu_ctr = ALU_SLT;  end
          3'b101:  begin ctrl.branch = BR_BGE;  ctrl.alu_ctr = ALU_SLT;  end
          3'b110:  begin ctrl.branch = BR_BLT;  ctrl.alu_ctr = ALU_SLTU; end
          3'b111:  begin ctrl.branch = BR_BGE;  ctrl.alu_ctr = ALU_SLTU; end
          default: ctrl.branch = BR_NONE;
        endcase
      end
      OPC_LOAD: begin
        reg_wr = 1'b1;  ctrl.mem_to_reg = 1'b1;  ctrl.imm = imm_i;
        ctrl.alu_b_src = SRC_B_IMM;  ctrl.mem_op = mem_op_e'(funct3);
      end
      OPC_STORE: begin
        ctrl.mem_wr = 1'b1;  ctrl.imm = imm_s;
        ctrl.alu_b_src = SRC_B_IMM;  ctrl.mem_op = mem_op_e'(funct3);
      end
      OPC_OP_IMM: begin
        reg_wr = 1'b1;  ctrl.imm = imm_i;  ctrl.alu_b_src = SRC_B_IMM;
        ctrl.alu_ctr = alu_from_funct(funct3, i_inst[30], 1'b0);
      end
      OPC_OP: begin
        reg_wr = 1'b1;
        ctrl.alu_ctr = alu_from_funct(funct3, i_inst[30], 1'b1);
      end
      default: reg_wr = 1'b0;  // Unknown opcode is a no-op
    endcase
  end

  assign ctrl.reg_wr = reg_wr && (i_inst[11:7] != 5'd0);  // Never write x0

endmodule

`default_nettype wire

// File: verilog/npc_exu.sv
// ALU with operand selection and compare flags
`default_nettype none

module npc_exu (
  npc_ctrl_if.exu_mp               ctrl,
  input  logic [npc_pkg::XLEN-1:0] i_rs1,
  input  logic [npc_pkg::XLEN-1:0] i_rs2,
  input  logic [npc_pkg::XLEN-1:0] i_pc,
  output logic [npc_pkg::XLEN-1:0] o_result,
  output logic                     o_less,
  output logic                     o_zero
);
  import npc_pkg::*;

  logic [XLEN-1:0] op_a, op_b;
  logic [5:0]      shamt;

  assign op_a = ctrl.alu_a_src ? i_pc : i_rs1;

  always_comb begin
    case (ctrl.alu_b_src)
      SRC_B_RS2: op_b = i_rs2;
      SRC_B_IMM: op_b = ctrl.imm;
      default:   op_b = XLEN'(4);
    endcase
  end

  assign shamt = op_b[5:0];

  always_comb begin
    case (ctrl.alu_ctr)
      ALU_ADD:    o_result = op_a + op_b;
      ALU_SUB:    o_result = op_a - op_b;
      ALU_SLL:    o_result = op_a << shamt;
      ALU_SLT:    o_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   o_result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    o_result = op_a ^ op_b;
      ALU_SRL:    o_result = op_a >> shamt;
      ALU_SRA:    o_result = $signed(op_a) >>> shamt;
      ALU_OR:     o_result = op_a | op_b;
      ALU_AND:    o_result = op_a & op_b;
      ALU_COPY_B: o_result = op_b;
      default:    o_result = '0;
    endcase
  end

  assign o_less = o_result[0];        // Valid for SLT/SLTU
  assign o_zero = (o_result == '0);   // Equality after SUB

endmodule

`default_nettype wire

// File: verilog/npc_gpr.sv
// 32 x 64 register file, two read ports and one write port
`default_nettype none

module npc_gpr (
  input  logic                     i_clk,
  input  logic [4:0]               i_ra,
  input  logic [4:0]               i_rb,
  input  logic [4:0]               i_waddr,
  input  logic [npc_pkg::XLEN-1:0] i_wdata,
  input  logic                     i_wen,
  output logic [npc_pkg::XLEN-1:0] o_bus_a,
  output logic [npc_pkg::XLEN-1:0] o_bus_b
);
  import npc_pkg::*;

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (i_wen) regs[i_waddr] <= i_wdata;
  end

  assign o_bus_a = (i_ra == 5'd0) ? '0 : regs[i_ra];  // x0 is hardwired zero
  assign o_bus_b = (i_rb == 5'd0) ? '0 : regs[i_rb];

endmodule

`default_nettype wire

// File: verilog/npc_lsu.sv
// Byte-addressed data memory with sized stores and extending loads
`default_nettype none

module npc_lsu #(
  parameter int DMEM_DEPTH = 512
) (
  input  logic                     i_clk,
  npc_ctrl_if.lsu_mp               ctrl,
  input  logic [npc_pkg::XLEN-1:0] i_addr,
  input  logic [npc_pkg::XLEN-1:0] i_wdata,
  output logic [npc_pkg::XLEN-1:0] o_rdata
);
  import npc_pkg::*;

  localparam int AW = $clog2(DMEM_DEPTH);

  logic [7:0]      dmem [DMEM_DEPTH];
  logic [AW-1:0]   byte_addr [8];
  logic [3:0]      nbytes;
  logic [XLEN-1:0] raw;

  always_comb begin
    case (ctrl.mem_op)
      MEM_B, MEM_BU: nbytes = 4'd1;
      MEM_H, MEM_HU: nbytes = 4'd2;
      MEM_W, MEM_WU: nbytes = 4'd4;
      default:       nbytes = 4'd8;
    endcase
  end

  // Little-endian lanes, address wraps at the memory depth
  always_comb begin
    for (int k = 0; k < 8; k++) begin
      byte_addr[k]     = i_addr[AW-1:0] + AW'(k);
      raw[8*k +: 8]    = dmem[byte_addr[k]];
    end
  end

  always_ff @(posedge i_clk) begin
    if (ctrl.mem_wr) begin
      for (int k = 0; k < 8; k++) begin
        if (k < nbytes) dmem[byte_addr[k]] <= i_wdata[8*k +: 8];
      end
    end
  end

  always_comb begin
    case (ctrl.mem_op)
      MEM_B:   o_rdata = {{(XLEN-8){raw[7]}}, raw[7:0]};
      MEM_H:   o_rdata = {{(XLEN-16){raw[15]}}, raw[15:0]};
      MEM_W:   o_rdata = {{(XLEN-32){raw[31]}}, raw[31:0]};
      MEM_BU:  o_rdata = {{(XLEN-8){1'b0}}, raw[7:0]};
      MEM_HU:  o_rdata = {{(XLEN-16){1'b0}}, raw[15:0]};
      MEM_WU:  o_rdata = {{(XLEN-32){1'b0}}, raw[31:0]};
      default: o_rdata = raw;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/npc_top.sv
// npc core top level connecting fetch, decode, execute, memory and trace ports
`default_nettype none

module npc_top #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 512
) (
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  logic                          i_imem_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
  input  logic [npc_pkg::ILEN-1:0]      i_imem_data,
  output logic [npc_pkg::XLEN-1:0]      o_pc,
  output logic [npc_pkg::ILEN-1:0]      o_inst,
  output logic                          o_wb_en,
  output logic [4:0]                    o_wb_addr,
  output logic [npc_pkg::XLEN-1:0]      o_wb_data,
  output logic                          o_mem_wr,
  output logic [npc_pkg::XLEN-1:0]      o_mem_addr,
  output logic [npc_pkg::XLEN-1:0]      o_mem_wdata
);
  import npc_pkg::*;

  logic [ILEN-1:0] inst, dec_inst;
  logic [XLEN-1:0] pc, rs1, rs2, alu_result, load_data, wb_data;
  logic            less, zero;

  npc_ctrl_if ctrl ();

  npc_ifu #(.IMEM_DEPTH(IMEM_DEPTH)) u_ifu (
    .i_clk(i_clk), .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr),
    .i_imem_data(i_imem_data), .i_pc(pc), .o_inst(inst)
  );

  // All-zero word decodes as a no-op, so reset blocks every write
  assign dec_inst = i_reset ? '0 : inst;

  npc_idu u_idu (.i_inst(dec_inst), .ctrl(ctrl));

  npc_gpr u_gpr (
    .i_clk(i_clk), .i_ra(ctrl.ra), .i_rb(ctrl.rb), .i_waddr(ctrl.rd),
    .i_wdata(wb_data), .i_wen(ctrl.reg_wr), .o_bus_a(rs1), .o_bus_b(rs2)
  );

  npc_exu u_exu (
    .ctrl(ctrl), .i_rs1(rs1), .i_rs2(rs2), .i_pc(pc),
    .o_result(alu_result), .o_less(less), .o_zero(zero)
  );

  npc_bru u_bru (
    .i_clk(i_clk), .i_reset(i_reset), .ctrl(ctrl), .i_rs1(rs1),
    .i_less(less), .i_zero(zero), .o_pc(pc)
  );

  npc_lsu #(.DMEM_DEPTH(DMEM_DEPTH)) u_lsu (
    .i_clk(i_clk), .ctrl(ctrl), .i_addr(alu_result), .i_wdata(rs2), .o_rdata(load_data)
  );

  assign wb_data = ctrl.mem_to_reg ? load_data : alu_result;

  // ##########################################################################
  // Trace ports
  assign o_pc        = pc;
  assign o_inst      = inst;
  assign o_wb_en     = ctrl.reg_wr;
  assign o_wb_addr   = ctrl.rd;
  assign o_wb_data   = wb_data;
  assign o_mem_wr    = ctrl.mem_wr;
  assign o_mem_addr  = alu_result;
  assign o_mem_wdata = rs2;

endmodule

`default_nettype wire

// File: test/npc_props.sv
// Concurrent assertions on the npc_top trace ports and their bind into the core
`default_nettype none

module npc_props (
  input logic                     i_clk,
  input logic                     i_reset,
  input logic [npc_pkg::XLEN-1:0] i_pc,
  input logic                     i_wb_en,
  input logic [4:0]               i_wb_addr,
  input logic                     i_mem_wr
);
  timeunit 1ns;
  timeprecision 100ps;

  quiet_in_reset: assert property (@(posedge i_clk) i_reset |-> !i_wb_en && !i_mem_wr)
    else $error("write enable high while reset is asserted");

  no_x0_write: assert property (@(posedge i_clk) i_wb_en |-> i_wb_addr != 5'd0)
    else $error("writeback enabled with x0 as destination");

  wb_or_store: assert property (@(posedge i_clk) !(i_wb_en && i_mem_wr))
    else $error("writeback and store in the same cycle");

  pc_aligned: assert property (@(posedge i_clk) disable iff (i_reset) i_pc[1:0] == 2'b00)
    else $error("PC is not word aligned");

endmodule

bind npc_top npc_props u_props (
  .i_clk(i_clk), .i_reset(i_reset), .i_pc(o_pc), .i_wb_en(o_wb_en),
  .i_wb_addr(o_wb_addr), .i_mem_wr(o_mem_wr)
);

`default_nettype wire

// File: test/npc_checker.sv
// Reference model of the core, reference step function and per-cycle comparison
`default_nettype none

module npc_checker #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 512
) (
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  logic                          i_imem_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
  input  logic [npc_pkg::ILEN-1:0]      i_imem_data,
  input  logic [npc_pkg::XLEN-1:0]      i_pc,
  input  logic [npc_pkg::ILEN-1:0]      i_inst,
  input  logic                          i_wb_en,
  input  logic [4:0]                    i_wb_addr,
  input  logic [npc_pkg::XLEN-1:0]      i_wb_data,
  input  logic                          i_mem_wr,
  input  logic [npc_pkg::XLEN-1:0]      i_mem_addr,
  input  logic [npc_pkg::XLEN-1:0]      i_mem_wdata,
  output int                            o_errors,
  output int                            o_checks
);
  timeunit 1ns;
  timeprecision 100ps;
  import npc_pkg::*;

  localparam int IAW = $clog2(IMEM_DEPTH);
  localparam int DAW = $clog2(DMEM_DEPTH);

  logic [ILEN-1:0] prog [IMEM_DEPTH];
  logic [XLEN-1:0] regs [32];
  logic [7:0]      dmem [DMEM_DEPTH];
  logic [XLEN-1:0] pc, next_pc, e_wb_data, e_st_addr, e_st_data;
  logic            e_wb_en, e_st_en;
  logic [4:0]      e_wb_addr;
  logic [DAW-1:0]  idx;
  int              e_st_len;

  function automatic logic [XLEN-1:0] sext(logic [XLEN-1:0] v, int n);
    return $signed(v << (XLEN - n)) >>> (XLEN - n);
  endfunction

  function automatic logic [XLEN-1:0] alu_value(logic [2:0] f3, logic alt,
                                                logic [XLEN-1:0] x, logic [XLEN-1:0] y);
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[5:0];
      3'd2:    return ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
      3'd3:    return (x < y) ? 64'd1 : 64'd0;
      3'd4:    return x ^ y;
      3'd5:    return alt ? XLEN'($signed(x) >>> y[5:0]) : x >> y[5:0];
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] f3, logic [XLEN-1:0] x,
                                        logic [XLEN-1:0] y);
    case (f3)
      3'd0:    return x == y;
      3'd1:    return x != y;
      3'd4:    return $signed(x) < $signed(y);
      3'd5:    return $signed(x) >= $signed(y);
      3'd6:    return x < y;
      3'd7:    return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  // Little-endian bytes with the width from f3[1:0] and zero extension when f3[2] is set
  function automatic logic [XLEN-1:0] load_value(logic [XLEN-1:0] ea, logic [2:0] f3);
    logic [XLEN-1:0] raw;
    logic [DAW-1:0]  a;
    int              n;
    raw = '0;
    n   = 1 << f3[1:0];
    for (int k = 0; k < n; k++) begin
      a = ea[DAW-1:0] + DAW'(k);
      raw[8*k +: 8] = dmem[a];
    end
    return (f3[2] || n == 8) ? raw : sext(raw, 8 * n);
  endfunction

  function automatic void npc_ref_step(
    input  logic [XLEN-1:0] cur_pc,
    input  logic [ILEN-1:0] inst,
    output logic [XLEN-1:0] nxt_pc,
    output logic            wb_en,
    output logic [4:0]      wb_addr,
    output logic [XLEN-1:0] wb_data,
    output logic            st_en,
    output logic [XLEN-1:0] st_addr,
    output logic [XLEN-1:0] st_data,
    output int              st_len
  );
    logic [XLEN-1:0] a, b, imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [2:0]      f3;
    a       = regs[inst[19:15]];
    b       = regs[inst[24:20]];
    f3      = inst[14:12];
    imm_i   = sext(XLEN'(inst[31:20]), 12);
    imm_s   = sext(XLEN'({inst[31:25], inst[11:7]}), 12);
    imm_b   = sext(XLEN'({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}), 13);
    imm_u   = sext(XLEN'({inst[31:12], 12'b0}), 32);
    imm_j   = sext(XLEN'({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}), 21);
    nxt_pc  = cur_pc + 64'd4;
    wb_en   = 1'b1;
    wb_addr = inst[11:7];
    wb_data = '0;
    st_en   = 1'b0;
    st_addr = a + imm_s;
    st_data = b;
    st_len  = 1 << f3[1:0];
    case (inst[6:0])
      OPC_LUI:    wb_data = imm_u;
      OPC_AUIPC:  wb_data = cur_pc + imm_u;
      OPC_JAL: begin
        wb_data = cur_pc + 64'd4;
        nxt_pc  = cur_pc + imm_j;
      end
      OPC_JALR: begin
        wb_data = cur_pc + 64'd4;
        nxt_pc  = (a + imm_i) & ~64'd1;
      end
      OPC_BRANCH: begin
        wb_en = 1'b0;
        if (branch_taken(f3, a, b)) nxt_pc = cur_pc + imm_b;
      end
      OPC_LOAD:   wb_data = load_value(a + imm_i, f3);
      OPC_STORE: begin
        wb_en = 1'b0;
        st_en = 1'b1;
      end
      OPC_OP_IMM: wb_data = alu_value(f3, inst[30] && f3 == 3'd5, a, imm_i);
      OPC_OP:     wb_data = alu_value(f3, inst[30], a, b);
      default:    wb_en = 1'b0;
    endcase
    if (wb_addr == 5'd0) wb_en = 1'b0;
  endfunction

  task automatic compare(input string name, input logic [XLEN-1:0] expected,
                         input logic [XLEN-1:0] actual);
    o_checks++;
    if (actual !== expected) begin
      o_errors++;
      $display("ERROR t=%0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  initial begin
    o_errors = 0;
    o_checks = 0;
    pc       = PC_RESET;
    for (int k = 0; k < 32; k++) regs[k] = '0;
  end

  // ##########################################################################
  // Sampled mid-cycle when the outputs have settled
  always @(negedge i_clk) begin
    if (i_imem_we) prog[i_imem_addr] = i_imem_data;  // Own copy of the program
    if (i_reset) begin
      pc = PC_RESET;
      compare("o_pc", PC_RESET, i_pc);
      compare("o_wb_en", '0, XLEN'(i_wb_en));
      compare("o_mem_wr", '0, XLEN'(i_mem_wr));
    end else begin
      npc_ref_step(pc, prog[pc[IAW+1:2]], next_pc, e_wb_en, e_wb_addr, e_wb_data,
                   e_st_en, e_st_addr, e_st_data, e_st_len);
      compare("o_pc", pc, i_pc);
      compare("o_inst", XLEN'(prog[pc[IAW+1:2]]), XLEN'(i_inst));
      compare("o_wb_en", XLEN'(e_wb_en), XLEN'(i_wb_en));
      if (e_wb_en) begin
        compare("o_wb_addr", XLEN'(e_wb_addr), XLEN'(i_wb_addr));
        compare("o_wb_data", e_wb_data, i_wb_data);
        regs[e_wb_addr] = e_wb_data;
      end
      compare("o_mem_wr", XLEN'(e_st_en), XLEN'(i_mem_wr));
      if (e_st_en) begin
        compare("o_mem_addr", e_st_addr, i_mem_addr);
        compare("o_mem_wdata", e_st_data, i_mem_wdata);
        for (int k = 0; k < e_st_len; k++) begin
          idx = e_st_addr[DAW-1:0] + DAW'(k);
          dmem[idx] = e_st_data[8*k +: 8];
        end
      end
      pc = next_pc;
    end
  end

endmodule

`default_nettype wire

// File: test/npc_tb.sv
// Testbench top with clock, reset, random program build and load, timeout and final report
`default_nettype none

module npc_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import npc_pkg::*;

  localparam int IMEM_DEPTH = 256;
  localparam int DMEM_DEPTH = 512;
  localparam int IAW        = $clog2(IMEM_DEPTH);

  logic            clk = 1'b0;
  logic            reset;
  logic            imem_we;
  logic [IAW-1:0]  imem_addr;
  logic [ILEN-1:0] imem_data, inst;
  logic [XLEN-1:0] pc, wb_data, mem_addr, mem_wdata, loop_pc;
  logic            wb_en, mem_wr;
  logic [4:0]      wb_addr;
  logic [ILEN-1:0] prog [$];
  int              errors, checks, seed, cycles, loop_cycles, limit, timeouts;

  npc_top #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) u_dut (
    .i_clk(clk), .i_reset(reset), .i_imem_we(imem_we), .i_imem_addr(imem_addr),
    .i_imem_data(imem_data), .o_pc(pc), .o_inst(inst), .o_wb_en(wb_en),
    .o_wb_addr(wb_addr), .o_wb_data(wb_data), .o_mem_wr(mem_wr),
    .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata)
  );

  npc_checker #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) u_checker (
    .i_clk(clk), .i_reset(reset), .i_imem_we(imem_we), .i_imem_addr(imem_addr),
    .i_imem_data(imem_data), .i_pc(pc), .i_inst(inst), .i_wb_en(wb_en),
    .i_wb_addr(wb_addr), .i_wb_data(wb_data), .i_mem_wr(mem_wr), .i_mem_addr(mem_addr),
    .i_mem_wdata(mem_wdata), .o_errors(errors), .o_checks(checks)
  );

  always #2 clk = ~clk;

  // ##########################################################################
  // Instruction encoders
  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                         logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(logic [2:0] f3, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  task automatic append(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic append_skip();
    append(i_type(OPC_OP_IMM, 3'd0, 5'd28, 5'd28, 12'd1));  // Visible only if not skipped
  endtask

  // ##########################################################################
  // Instruction groups
  task automatic random_alu();
    logic [31:0] r;
    logic [11:0] imm;
    r   = next_rand();
    imm = r[30:19];
    if (r[31]) begin
      append(r_type((r[3] && (r[2:0] == 3'd0 || r[2:0] == 3'd5)) ? 7'h20 : 7'h00,
                    r[18:14], r[13:9], r[2:0], r[8:4]));
    end else begin
      if (r[2:0] == 3'd1) imm = {6'b0, imm[5:0]};
      else if (r[2:0] == 3'd5) imm = {1'b0, r[3], 4'b0, imm[5:0]};  // SRLI or SRAI
      append(i_type(OPC_OP_IMM, r[2:0], r[8:4], r[13:9], imm));
    end
  endtask

  task automatic load_op(input logic [2:0] f3, input logic [11:0] off);
    logic [31:0] r;
    r = next_rand();
    append(i_type(OPC_LOAD, f3, {1'b0, r[3:0]} + 5'd1, 5'd31, off));
  endtask

  task automatic mem_group();
    logic [31:0] r;
    r = next_rand();
    append(i_type(OPC_OP_IMM, 3'd0, 5'd31, 5'd0, {3'b000, r[5:0], 3'b000}));
    append(s_type(3'd3, r[10:6], 5'd31, 12'd0));   // SD fills the doubleword
    append(s_type(3'd0, r[15:11], 5'd31, 12'd1));  // Partial overwrites
    append(s_type(3'd1, r[20:16], 5'd31, 12'd2));
    append(s_type(3'd2, r[25:21], 5'd31, 12'd4));
    load_op(3'd0, 12'd1);
    load_op(3'd4, 12'd7);
    load_op(3'd1, 12'd2);
    load_op(3'd5, 12'd6);
    load_op(3'd2, 12'd4);
    load_op(3'd6, 12'd0);
    load_op(3'd3, 12'd0);
  endtask

  task automatic branch_group();
    logic [31:0] r;
    r = next_rand();
    append(i_type(OPC_OP_IMM, 3'd0, 5'd29, 5'd0, {2'b11, r[9:0]}));
    append(i_type(OPC_OP_IMM, 3'd0, 5'd30, 5'd0, {3'b000, r[18:10]} + 12'd1));
    for (int k = 0; k < 8; k++) begin
      if (k != 2 && k != 3) begin
        append(b_type(3'(k), 5'd29, 5'd29, 13'd8));  // Equal operands
        append_skip();
        append(b_type(3'(k), 5'd29, 5'd30, 13'd8));  // Negative x29 against positive x30
        append_skip();
        append(b_type(3'(k), 5'd30, 5'd29, 13'd8));  // Swapped operands
        append_skip();
      end
    end
  endtask

  task automatic jump_group();
    logic [31:0] r;
    r = next_rand();
    append(j_type(r[4:0], 21'd8));
    append_skip();
    append(u_type(OPC_AUIPC, 5'd27, 20'd0));
    append(i_type(OPC_JALR, 3'd0, r[9:5], 5'd27, 12'd13));  // Odd offset with bit 0 dropped
    append_skip();
  endtask

  task automatic upper_group();
    logic [31:0] r;
    r = next_rand();
    append(u_type(OPC_LUI, r[4:0], {1'b1, r[23:5]}));
    append(u_type(OPC_LUI, r[9:5], {1'b0, r[28:10]}));
    r = next_rand();
    append(u_type(OPC_AUIPC, r[4:0], r[24:5]));
  endtask

  task automatic build_program();
    for (int k = 1; k < 32; k++) begin
      append(i_type(OPC_OP_IMM, 3'd0, 5'(k), 5'd0, 12'(next_rand())));
    end
    append(i_type(OPC_OP_IMM, 3'd0, 5'd0, 5'd1, 12'h123));  // Dropped write to x0
    append(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd26));
    repeat (10) random_alu();
    mem_group();
    repeat (10) random_alu();
    upper_group();
    jump_group();
    repeat (10) random_alu();
    branch_group();
    repeat (8) random_alu();
    mem_group();
    loop_pc = XLEN'(4 * prog.size());
    append(j_type(5'd0, 21'd0));  // Self-loop
  endtask

  // ##########################################################################
  // Load under reset, run, report
  initial begin
    reset     = 1'b1;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    seed      = 29788;
    timeouts  = 0;
    build_program();
    limit = 2 * prog.size() + 20;
    foreach (prog[k]) begin
      @(posedge clk);
      #1;
      imem_we   = 1'b1;
      imem_addr = IAW'(k);
      imem_data = prog[k];
    end
    @(posedge clk);
    #1;
    imem_we = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset       = 1'b0;
    cycles      = 0;
    loop_cycles = 0;
    while (loop_cycles < 4 && cycles < limit) begin
      @(negedge clk);
      cycles++;
      if (pc == loop_pc) loop_cycles++;
      else loop_cycles = 0;
    end
    if (loop_cycles < 4) begin
      $display("Timeout: the program did not reach its final loop within %0d cycles", limit);
      timeouts = 1;
    end
    @(posedge clk);
    $display("Checks: %0d  errors: %0d", checks, errors + timeouts);
    if (errors + timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: npc.f
verilog/npc_pkg.sv
verilog/npc_ctrl_if.sv
verilog/npc_ifu.sv
verilog/npc_bru.sv
verilog/npc_idu.sv
verilog/npc_exu.sv
verilog/npc_gpr.sv
verilog/npc_lsu.sv
verilog/npc_top.sv
test/npc_props.sv
test/npc_checker.sv
test/npc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the npc testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module npc_tb -f npc.f -o npc_sim
./obj_dir/npc_sim | tee sim.log

if grep -qx "All tests passed" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi
